// File: tb.f
design/noc_pkg.sv
design/vc_fifo.sv
design/vc_selector.sv
design/input_router.sv
design/input_unit.sv
tests/input_unit_assertions.sv
tests/tb_input_unit.sv

// File: Bender.yml
package:
  name: noc_input_unit

sources:
  - design/noc_pkg.sv
  - design/vc_fifo.sv
  - design/vc_selector.sv
  - design/input_router.sv
  - design/input_unit.sv
  - target: test
    files:
      - tests/input_unit_assertions.sv
      - tests/tb_input_unit.sv

// File: tests/tb_input_unit.sv
// input unit testbench
// random interleaved packets on all vcs, checked against a queue, route
// and round-robin model of the input unit
module tb_input_unit;

  localparam int N_VC       = noc_pkg::N_VIRT_CHN;
  localparam int FIFO_DEPTH = 4;
  localparam int N_PKT      = 60;
  localparam int MY_X       = 3;
  localparam int MY_Y       = 2;
  localparam int LIMIT      = N_PKT * 5 * 8 * 40;    // watchdog budget

  logic               clk = 1'b0;
  logic               arst;
  logic               flit_valid_i;
  noc_pkg::flit_t     flit_i;
  noc_pkg::vc_id_t    flit_vc_i;
  logic [N_VC-1:0]    vc_full_o;
  logic               out_ready_i;
  logic               out_valid_o;
  noc_pkg::flit_t     out_flit_o;
  noc_pkg::vc_id_t    out_vc_o;
  noc_pkg::port_req_t port_req_o;

  integer         seed = 32'h1066;
  noc_pkg::flit_t exp_q [N_VC][$];                   // written, not yet out
  noc_pkg::flit_t send_q [N_VC][$];                  // built, not yet strobed
  logic [4:0]     exp_rt [N_VC];                     // route of last head
  int             rr_ptr;                            // model priority vc
  int             n_pkt;
  logic           checking;
  logic           hold_prev;                         // output must not move
  logic [38:0]    prev_out;
  logic [38:0]    out_bus;

  assign out_bus = {out_valid_o, out_vc_o, port_req_o, out_flit_o};

  input_unit #(
    .ROUTER_X_ID(MY_X),
    .ROUTER_Y_ID(MY_Y),
    .FIFO_DEPTH (FIFO_DEPTH),
    .N_VC       (N_VC)
  ) dut0 (
    .clk         (clk),
    .arst        (arst),
    .flit_valid_i(flit_valid_i),
    .flit_i      (flit_i),
    .flit_vc_i   (flit_vc_i),
    .vc_full_o   (vc_full_o),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o),
    .out_vc_o    (out_vc_o),
    .port_req_o  (port_req_o)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_eq(input string test, input logic [38:0] exp, input logic [38:0] act);
    assert (exp === act) else begin
      $display("mismatch %s: expected %0h actual %0h", test, exp, act);
      abort_run();
    end
  endtask

  // dimension ordered, x first; one-hot north south west east local
  function automatic logic [4:0] xy_route(input noc_pkg::flit_t f);
    int x;
    int y;
    x = f[29:27];
    y = f[26:24];
    if (x == MY_X && y == MY_Y) return 5'b00001;
    if (x == MY_X) return (y < MY_Y) ? 5'b01000 : 5'b10000;
    return (x < MY_X) ? 5'b00100 : 5'b00010;
  endfunction

  function automatic int flits_in_flight();
    int n;
    n = 0;
    for (int v = 0; v < N_VC; v++) n += exp_q[v].size();
    return n;
  endfunction

  function automatic int flits_to_send();
    int n;
    n = 0;
    for (int v = 0; v < N_VC; v++) n += send_q[v].size();
    return n;
  endfunction

  // head, 0 to 3 bodies, tail
  task automatic make_packet(input int v);
    int n_body;
    int x;
    int y;
    n_body = {$random(seed)} % 4;
    x      = {$random(seed)} % 8;
    y      = {$random(seed)} % 8;
    case (n_pkt)                                     // local, then s n w e
      0: begin x = 3; y = 2; end
      1: begin x = 3; y = 0; end
      2: begin x = 3; y = 6; end
      3: begin x = 0; y = 5; end
      4: begin x = 7; y = 1; end
      default: ;
    endcase
    send_q[v].push_back({2'b00, x[2:0], y[2:0], 24'(n_pkt)});
    for (int i = 0; i < n_body; i++) begin
      send_q[v].push_back({2'b01, 30'($random(seed))});
    end
    send_q[v].push_back({2'b10, 30'($random(seed))});
    n_pkt++;
  endtask

  // sampled mid-cycle, where inputs and outputs are settled
  always @(negedge clk) begin
    int             occ [N_VC];
    int             sel;
    logic [4:0]     rt;
    noc_pkg::flit_t f;
    if (checking) begin
      sel = -1;
      for (int v = 0; v < N_VC; v++) begin
        occ[v] = exp_q[v].size() - ((flit_valid_i && flit_vc_i == v) ? 1 : 0);
        expect_eq("full flag", occ[v] == FIFO_DEPTH, vc_full_o[v]);
      end
      for (int i = 0; i < N_VC; i++) begin
        if (sel < 0 && occ[(rr_ptr + i) % N_VC] > 0) sel = (rr_ptr + i) % N_VC;
      end
      if (hold_prev) expect_eq("back-pressure hold", prev_out, out_bus);
      expect_eq("out valid", sel >= 0, out_valid_o);
      if (sel >= 0) begin
        f  = exp_q[sel][0];
        rt = (f[31:30] == 2'b00) ? xy_route(f) : exp_rt[sel];
        expect_eq("round-robin vc", sel, out_vc_o);
        expect_eq("flit order", f, out_flit_o);
        expect_eq((f[31:30] == 2'b00) ? "head route" : "table route", rt, port_req_o);
        if (out_ready_i) begin                       // transfer on next edge
          f           = exp_q[sel].pop_front();
          exp_rt[sel] = rt;
          rr_ptr      = (sel + 1) % N_VC;
        end
      end
      // a write into an idle vc may legally change the pick
      hold_prev = out_valid_o && !out_ready_i && !(flit_valid_i && occ[flit_vc_i] == 0);
      prev_out  = out_bus;
    end
  end

  initial begin
    #(LIMIT);
    $display("timeout: flits still outstanding after %0d time units", LIMIT);
    abort_run();
  end

  initial begin
    int v;
    arst         = 1'b1;
    flit_valid_i = 1'b0;
    flit_i       = '0;
    flit_vc_i    = '0;
    out_ready_i  = 1'b0;
    checking     = 1'b0;
    hold_prev    = 1'b0;
    prev_out     = '0;
    rr_ptr       = 0;
    n_pkt        = 0;
    for (int i = 0; i < N_VC; i++) exp_rt[i] = '0;
    repeat (5) @(posedge clk);
    #2 arst = 1'b0;
    @(negedge clk);
    expect_eq("reset", '0, {out_valid_o, vc_full_o, port_req_o});
    checking = 1'b1;
    while (n_pkt < N_PKT || flits_to_send() > 0) begin
      @(posedge clk);
      #2;
      out_ready_i  = ({$random(seed)} % 10) >= 3;    // ~30 percent stall
      flit_valid_i = 1'b0;
      v            = {$random(seed)} % N_VC;
      if (send_q[v].size() == 0 && n_pkt < N_PKT) make_packet(v);
      if (send_q[v].size() > 0 && !vc_full_o[v] && ({$random(seed)} % 4) != 0) begin
        flit_i       = send_q[v].pop_front();
        flit_vc_i    = noc_pkg::vc_id_t'(v);
        flit_valid_i = 1'b1;
        exp_q[v].push_back(flit_i);
      end
    end
    @(posedge clk);
    #2;
    flit_valid_i = 1'b0;
    out_ready_i  = 1'b1;                             // drain
    while (flits_in_flight() > 0) @(posedge clk);
    @(negedge clk);                                  // last transfer has landed
    if (out_valid_o === 1'b0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("mismatch drain: expected out valid 0 actual %0b", out_valid_o);
      abort_run();
    end
  end

endmodule

// File: tests/input_unit_assertions.sv
// input unit assertions
// link and crossbar side protocol checks, bound into input_unit
module input_unit_assertions #(
  parameter int N_VC = noc_pkg::N_VIRT_CHN
) (
  input logic               clk,
  input logic               arst,
  input logic               flit_valid_i,
  input noc_pkg::vc_id_t    flit_vc_i,
  input logic [N_VC-1:0]    vc_full_o,
  input logic               out_ready_i,
  input logic               out_valid_o,
  input noc_pkg::flit_t     out_flit_o,
  input noc_pkg::vc_id_t    out_vc_o,
  input noc_pkg::port_req_t port_req_o,
  input logic [N_VC-1:0]    wr_en,              // per-fifo push
  input logic [N_VC-1:0]    vc_empty
);

  logic wake_vc;                                // idle vc gets a flit

  assign wake_vc = |(wr_en & vc_empty);

  // an offered flit asks for exactly one port, an idle output for none
  a_req_onehot: assert property (@(posedge clk) disable iff (arst)
    out_valid_o ? $onehot(port_req_o) : (port_req_o == '0))
    else $error("port request is not one-hot for a valid flit or not zero when idle");

  // stalled output holds unless a newly filled vc takes the pick
  a_stall_hold: assert property (@(posedge clk) disable iff (arst)
    out_valid_o && !out_ready_i && !wake_vc |=>
      out_valid_o && $stable(out_flit_o) && $stable(out_vc_o) && $stable(port_req_o))
    else $error("output changed while the crossbar was not ready");

  a_no_full_write: assert property (@(posedge clk) disable iff (arst)
    flit_valid_i |-> !vc_full_o[flit_vc_i])
    else $error("flit strobed into a full vc");

endmodule

bind input_unit input_unit_assertions #(
  .N_VC(N_VC)
) u_assertions (
  .clk         (clk),
  .arst        (arst),
  .flit_valid_i(flit_valid_i),
  .flit_vc_i   (flit_vc_i),
  .vc_full_o   (vc_full_o),
  .out_ready_i (out_ready_i),
  .out_valid_o (out_valid_o),
  .out_flit_o  (out_flit_o),
  .out_vc_o    (out_vc_o),
  .port_req_o  (port_req_o),
  .wr_en       (wr_en),
  .vc_empty    (vc_empty)
);

// File: design/input_unit.sv
// input unit
// one router input link: per-vc flit fifos, round-robin vc pick and
// output port request toward the crossbar
module input_unit #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0,
  parameter int FIFO_DEPTH  = 4,
  parameter int N_VC        = noc_pkg::N_VIRT_CHN
) (
  input  logic               clk,
  input  logic               arst,
  input  logic               flit_valid_i,      // one-cycle strobe
  input  noc_pkg::flit_t     flit_i,
  input  noc_pkg::vc_id_t    flit_vc_i,
  output logic [N_VC-1:0]    vc_full_o,         // sender must hold off
  input  logic               out_ready_i,       // crossbar takes the flit
  output logic               out_valid_o,
  output noc_pkg::flit_t     out_flit_o,
  output noc_pkg::vc_id_t    out_vc_o,
  output noc_pkg::port_req_t port_req_o
);

  logic [N_VC-1:0] wr_en;                       // per-fifo push
  logic [N_VC-1:0] vc_empty;
  logic [N_VC-1:0] vc_pop;
  noc_pkg::flit_t  head_flit [N_VC];            // each fifo head
  logic            xfer;

  // steer the strobe to the addressed vc
  always_comb begin
    wr_en = '0;
    if (flit_valid_i) begin
      wr_en[flit_vc_i] = 1'b1;
    end
  end

  for (genvar v = 0; v < N_VC; v++) begin : g_vc
    vc_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
      .clk    (clk),
      .arst   (arst),
      .wr_i   (wr_en[v]),
      .wdata_i(flit_i),
      .rd_i   (vc_pop[v]),
      .rdata_o(head_flit[v]),
      .empty_o(vc_empty[v]),
      .full_o (vc_full_o[v])
    );
  end

  vc_selector #(
    .N_VC(N_VC)
  ) u_sel (
    .clk        (clk),
    .arst       (arst),
    .empty_i    (vc_empty),
    .out_ready_i(out_ready_i),
    .sel_valid_o(out_valid_o),
    .sel_vc_o   (out_vc_o),
    .pop_o      (vc_pop)
  );

  assign out_flit_o = head_flit[out_vc_o];      // chosen head to crossbar
  assign xfer       = out_valid_o && out_ready_i;

  input_router #(
    .ROUTER_X_ID(ROUTER_X_ID),
    .ROUTER_Y_ID(ROUTER_Y_ID),
    .N_VC       (N_VC)
  ) u_router (
    .clk       (clk),
    .arst      (arst),
    .valid_i   (out_valid_o),
    .flit_i    (out_flit_o),
    .vc_i      (out_vc_o),
    .advance_i (xfer),
    .port_req_o(port_req_o)
  );

endmodule

// File: design/input_router.sv
// input router
// xy route decode for head flits, per-vc routing table keeps the route
// of the open packet for its body and tail flits
module input_router #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0,
  parameter int N_VC        = noc_pkg::N_VIRT_CHN
) (
  input  logic               clk,
  input  logic               arst,
  input  logic               valid_i,           // flit offered to crossbar
  input  noc_pkg::flit_t     flit_i,
  input  noc_pkg::vc_id_t    vc_i,
  input  logic               advance_i,         // flit transfers this edge
  output noc_pkg::port_req_t port_req_o
);

  localparam noc_pkg::coord_t MY_X = noc_pkg::coord_t'(ROUTER_X_ID);
  localparam noc_pkg::coord_t MY_Y = noc_pkg::coord_t'(ROUTER_Y_ID);

  noc_pkg::routes_t   rt_table [N_VC];          // last head route per vc
  noc_pkg::routes_t   head_rt;                  // xy result
  noc_pkg::routes_t   cur_rt;                   // route of offered flit
  noc_pkg::flit_type_t ftype;
  noc_pkg::coord_t    x_dest;
  noc_pkg::coord_t    y_dest;
  logic               is_head;

  // header fields
  assign ftype   = noc_pkg::flit_type_t'(flit_i[noc_pkg::FTYPE_MSB:noc_pkg::FTYPE_LSB]);
  assign x_dest  = flit_i[noc_pkg::X_DEST_MSB:noc_pkg::X_DEST_LSB];
  assign y_dest  = flit_i[noc_pkg::Y_DEST_MSB:noc_pkg::Y_DEST_LSB];
  assign is_head = valid_i && (ftype == noc_pkg::HEAD_FLIT);

  // dimension ordered, x first then y
  always_comb begin
    if (x_dest == MY_X && y_dest == MY_Y) begin
      head_rt = noc_pkg::LOCAL_PORT;            // arrived
    end else if (x_dest == MY_X) begin
      head_rt = (y_dest < MY_Y) ? noc_pkg::SOUTH_PORT : noc_pkg::NORTH_PORT;
    end else begin
      head_rt = (x_dest < MY_X) ? noc_pkg::WEST_PORT : noc_pkg::EAST_PORT;
    end
  end

  // heads decode, the rest follow the table
  assign cur_rt = is_head ? head_rt :
                  valid_i ? rt_table[vc_i] : noc_pkg::NO_ROUTE;

  always_comb begin
    port_req_o = '0;
    case (cur_rt)
      noc_pkg::NORTH_PORT: port_req_o[noc_pkg::NORTH_BIT] = 1'b1;
      noc_pkg::SOUTH_PORT: port_req_o[noc_pkg::SOUTH_BIT] = 1'b1;
      noc_pkg::WEST_PORT:  port_req_o[noc_pkg::WEST_BIT]  = 1'b1;
      noc_pkg::EAST_PORT:  port_req_o[noc_pkg::EAST_BIT]  = 1'b1;
      noc_pkg::LOCAL_PORT: port_req_o[noc_pkg::LOCAL_BIT] = 1'b1;
      default:             port_req_o = '0;    // no_route gives no request
    endcase
  end

  // table written only when the head actually leaves
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      for (int i = 0; i < N_VC; i++) begin
        rt_table[i] <= noc_pkg::NO_ROUTE;
      end
    end else if (advance_i && is_head) begin
      rt_table[vc_i] <= head_rt;
    end
  end

endmodule

// File: design/vc_selector.sv
// vc selector
// round-robin pick among the non-empty vc fifos, one flit per cycle,
// pops the chosen head when the crossbar is ready
module vc_selector #(
  parameter int N_VC = noc_pkg::N_VIRT_CHN
) (
  input  logic            clk,
  input  logic            arst,
  input  logic [N_VC-1:0] empty_i,              // per-vc fifo empty
  input  logic            out_ready_i,          // crossbar can take a flit
  output logic            sel_valid_o,          // some vc has a flit
  output noc_pkg::vc_id_t sel_vc_o,             // chosen vc
  output logic [N_VC-1:0] pop_o                 // one-hot pop
);

  noc_pkg::vc_id_t rr_ptr;                      // highest priority vc
  noc_pkg::vc_id_t next_ptr;
  logic            xfer;

  // first non-empty vc at or after the pointer
  always_comb begin
    int unsigned cand;
    sel_valid_o = 1'b0;
    sel_vc_o    = '0;
    // walk backwards so the closest candidate is assigned last
    for (int i = N_VC - 1; i >= 0; i--) begin
      cand = (int'(rr_ptr) + i) % N_VC;
      if (!empty_i[cand]) begin
        sel_valid_o = 1'b1;
        sel_vc_o    = noc_pkg::vc_id_t'(cand);
      end
    end
  end

  assign xfer = sel_valid_o && out_ready_i;     // flit leaves this cycle

  always_comb begin
    pop_o = '0;
    if (xfer) begin
      pop_o[sel_vc_o] = 1'b1;
    end
  end

  // pointer moves one past the winner
  assign next_ptr = noc_pkg::vc_id_t'((int'(sel_vc_o) + 1) % N_VC);

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      rr_ptr <= '0;                             // vc 0 first after reset
    end else if (xfer) begin
      rr_ptr <= next_ptr;
    end
  end

endmodule

// File: design/vc_fifo.sv
// vc fifo
// flit buffer for one virtual channel, register array with
// extended pointers, head flit read combinationally
module vc_fifo #(
  parameter int FIFO_DEPTH = 4                  // power of two, 2 or more
) (
  input  logic           clk,
  input  logic           arst,
  input  logic           wr_i,                  // push strobe
  input  noc_pkg::flit_t wdata_i,
  input  logic           rd_i,                  // pop strobe
  output noc_pkg::flit_t rdata_o,               // current head
  output logic           empty_o,
  output logic           full_o
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  noc_pkg::flit_t    mem [FIFO_DEPTH];          // flit storage
  logic [ADDR_W:0]   wr_ptr;                    // extra msb tells wrap
  logic [ADDR_W:0]   rd_ptr;
  logic              wr_en;
  logic              rd_en;

  // flags from pointer compare
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                   (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  // a pop in the same edge frees the slot, so push is taken when full
  assign rd_en = rd_i && !empty_o;
  assign wr_en = wr_i && (!full_o || rd_en);

  assign rdata_o = mem[rd_ptr[ADDR_W-1:0]];     // fall-through head

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;                // wraps with the msb
      end
    end
  end

  // storage, written at the tail slot
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= wdata_i;
    end
  end

endmodule

// File: design/noc_pkg.sv
// noc package
// flit layout, flit types, route codes and width typedefs shared by the
// input unit of one mesh router
package noc_pkg;

  // network sizing
  localparam int FLIT_W     = 32;               // full flit width
  localparam int N_VIRT_CHN = 2;                // default number of VCs
  localparam int COORD_W    = 3;                // one mesh coordinate
  localparam int VC_ID_W    = (N_VIRT_CHN > 1) ? $clog2(N_VIRT_CHN) : 1;

  // width typedefs
  typedef logic [FLIT_W-1:0]  flit_t;           // raw flit
  typedef logic [VC_ID_W-1:0] vc_id_t;          // vc index
  typedef logic [COORD_W-1:0] coord_t;          // x or y coordinate

  // flit type field, top two bits of every flit
  typedef enum logic [1:0] {
    HEAD_FLIT = 2'd0,                           // carries destination
    BODY_FLIT = 2'd1,
    TAIL_FLIT = 2'd2                            // closes the packet
  } flit_type_t;

  // field positions inside a flit
  localparam int FTYPE_MSB  = 31;
  localparam int FTYPE_LSB  = 30;
  localparam int X_DEST_MSB = 29;               // head flits only
  localparam int X_DEST_LSB = 27;
  localparam int Y_DEST_MSB = 26;               // head flits only
  localparam int Y_DEST_LSB = 24;

  // route codes, as kept in the per-vc routing table
  typedef enum logic [2:0] {
    NO_ROUTE   = 3'd0,                          // table empty after reset
    NORTH_PORT = 3'd1,
    SOUTH_PORT = 3'd2,
    WEST_PORT  = 3'd3,
    EAST_PORT  = 3'd4,
    LOCAL_PORT = 3'd5
  } routes_t;

  // one-hot request toward the crossbar, north in the msb
  localparam int N_PORTS = 5;
  typedef logic [N_PORTS-1:0] port_req_t;

  localparam int NORTH_BIT = 4;
  localparam int SOUTH_BIT = 3;
  localparam int WEST_BIT  = 2;
  localparam int EAST_BIT  = 1;
  localparam int LOCAL_BIT = 0;

endpackage
